//--- verilog/neoVideoPkg.sv
// Shared definitions for the video output path
// Palette word, pixel index and palette address types
// Output channel type, pixel divide and palette depth constants

package neoVideoPkg;

	// ==============================
	// Constants
	// ==============================

	// 48 MHz cycles per 6 MHz pixel
	localparam int PIXEL_DIVIDE = 8;

	// Two banks of 4096 words
	localparam int PAL_DEPTH = 8192;

	// ==============================
	// Types
	// ==============================

	// Palette entry
	// [15] dark, [14:12] R/G/B low bits, [11:8] R, [7:4] G, [3:0] B
	typedef logic [15:0] colorWordT;

	// Index within one palette bank
	typedef logic [11:0] pixelIndexT;

	// Full palette address, top bit selects the bank
	typedef logic [12:0] palAddrT;

	// One 8-bit output colour channel
	typedef logic [7:0] channelT;

	// Position inside one pixel period
	typedef logic [$clog2(PIXEL_DIVIDE)-1:0] pixelCountT;

	// Last count of a pixel period, where the enable fires
	localparam pixelCountT PIXEL_LAST = pixelCountT'(PIXEL_DIVIDE - 1);

endpackage

//--- verilog/pixelBus.sv
// Pixel bus between palette lookup and colour conversion
// Carries one palette word and the attributes of the same pixel

`timescale 1ns/100ps

interface pixelBus;

	// Palette word read for this pixel
	neoVideoPkg::colorWordT colorWord;

	// Attributes sampled together with the index
	logic shadow;
	logic videoEnable;
	logic hBlank;
	logic vBlank;

	// One-cycle strobe, new pixel present
	logic valid;

	modport source (
		output colorWord, shadow, videoEnable, hBlank, vBlank, valid
	);

	modport sink (
		input colorWord, shadow, videoEnable, hBlank, vBlank, valid
	);

endinterface

//--- verilog/pixelClockGen.sv
// Pixel clock enable generator
// Divides the 48 MHz clock down to a 6 MHz one-cycle enable

`timescale 1ns/100ps

module pixelClockGen (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic pixelCe
);

	neoVideoPkg::pixelCountT pixelCount;

	// Wraps after the last cycle of each pixel
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			pixelCount <= '0;
		end else if (pixelCount == neoVideoPkg::PIXEL_LAST) begin
			pixelCount <= '0;
		end else begin
			pixelCount <= pixelCount + 1'b1;
		end
	end

	// One pulse per pixel period
	assign pixelCe = (pixelCount == neoVideoPkg::PIXEL_LAST);

	// ==============================
	// Checks
	// ==============================

	// Enable is a single-cycle pulse
	pixelCeSingle: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		pixelCe |=> !pixelCe
	);

endmodule

//--- verilog/paletteLookup.sv
// Palette RAM and pixel read stage
// CPU write port, two banks selected by palBank
// Registers the palette word and the attributes of each pixel

`timescale 1ns/100ps

module paletteLookup (
	input  logic                    CLK_48M,
	input  logic                    nRESET,
	input  logic                    pixelCe,

	// CPU side
	input  logic                    palWrite,
	input  neoVideoPkg::palAddrT    palAddr,
	input  neoVideoPkg::colorWordT  palData,

	// Pixel stream
	input  neoVideoPkg::pixelIndexT pixelIndex,
	input  logic                    palBank,
	input  logic                    shadow,
	input  logic                    videoEnable,
	input  logic                    hBlank,
	input  logic                    vBlank,

	pixelBus.source                 pixOut
);

	neoVideoPkg::colorWordT palRam [neoVideoPkg::PAL_DEPTH];

	neoVideoPkg::palAddrT   readAddr;
	neoVideoPkg::colorWordT readWord;

	logic shadowReg;
	logic enableReg;
	logic hBlankReg;
	logic vBlankReg;
	logic validReg;

	// ==============================
	// CPU write port
	// ==============================

	always_ff @(posedge CLK_48M) begin
		if (palWrite) begin
			palRam[palAddr] <= palData;
		end
	end

	// ==============================
	// Pixel read port
	// ==============================

	// Bank bit on top of the per-bank index
	assign readAddr = {palBank, pixelIndex};

	// Old word is returned on a same-cycle write
	always_ff @(posedge CLK_48M) begin
		if (pixelCe) begin
			readWord  <= palRam[readAddr];
			shadowReg <= shadow;
			enableReg <= videoEnable;
			hBlankReg <= hBlank;
			vBlankReg <= vBlank;
		end
	end

	// Marks the cycle after each sample
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			validReg <= 1'b0;
		end else begin
			validReg <= pixelCe;
		end
	end

	assign pixOut.colorWord   = readWord;
	assign pixOut.shadow      = shadowReg;
	assign pixOut.videoEnable = enableReg;
	assign pixOut.hBlank      = hBlankReg;
	assign pixOut.vBlank      = vBlankReg;
	assign pixOut.valid       = validReg;

endmodule

//--- verilog/colorConvert.sv
// Colour conversion stage
// Expands palette words to 8-bit RGB with dark bit clamping
// Applies shadow and video enable, registers colour and blanks

`timescale 1ns/100ps

module colorConvert (
	input  logic                 CLK_48M,
	input  logic                 nRESET,
	pixelBus.sink                pixIn,
	output neoVideoPkg::channelT red,
	output neoVideoPkg::channelT green,
	output neoVideoPkg::channelT blue,
	output logic                 hBlank,
	output logic                 vBlank,
	output logic                 cePixel
);

	neoVideoPkg::channelT redNext;
	neoVideoPkg::channelT greenNext;
	neoVideoPkg::channelT blueNext;

	// ==============================
	// Channel expansion
	// ==============================

	// nibble, low bit, nibble MSB again, minus dark, clamp at zero
	function automatic neoVideoPkg::channelT expandChannel(
		input logic [3:0] nibble,
		input logic       lowBit,
		input logic       dark
	);
		logic [6:0] level;
		level = {1'b0, nibble, lowBit, nibble[3]} - {6'd0, dark};
		if (level[6]) begin
			return '0;
		end
		return {level[5:0], level[4:3]};
	endfunction

	// Shadow halves, disabled video is black
	function automatic neoVideoPkg::channelT shadeChannel(
		input neoVideoPkg::channelT level,
		input logic                 shadow,
		input logic                 enable
	);
		if (!enable) begin
			return '0;
		end
		return shadow ? {1'b0, level[7:1]} : level;
	endfunction

	assign redNext = shadeChannel(
		expandChannel(pixIn.colorWord[11:8], pixIn.colorWord[14], pixIn.colorWord[15]),
		pixIn.shadow, pixIn.videoEnable);
	assign greenNext = shadeChannel(
		expandChannel(pixIn.colorWord[7:4], pixIn.colorWord[13], pixIn.colorWord[15]),
		pixIn.shadow, pixIn.videoEnable);
	assign blueNext = shadeChannel(
		expandChannel(pixIn.colorWord[3:0], pixIn.colorWord[12], pixIn.colorWord[15]),
		pixIn.shadow, pixIn.videoEnable);

	// ==============================
	// Output registers
	// ==============================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red     <= '0;
			green   <= '0;
			blue    <= '0;
			hBlank  <= 1'b0;
			vBlank  <= 1'b0;
			cePixel <= 1'b0;
		end else begin
			cePixel <= pixIn.valid;
			if (pixIn.valid) begin
				red    <= redNext;
				green  <= greenNext;
				blue   <= blueNext;
				hBlank <= pixIn.hBlank;
				vBlank <= pixIn.vBlank;
			end
		end
	end

	// Blanked video reaches the pins as black
	videoOffBlack: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		(pixIn.valid && !pixIn.videoEnable) |=> (red == '0 && green == '0 && blue == '0)
	);

endmodule

//--- verilog/neoVideoOut.sv
// Video output path top level
// Pixel enable, palette lookup and colour conversion
// Pixel stream and palette writes on plain ports

`timescale 1ns/100ps

module neoVideoOut (
	input  logic                    CLK_48M,
	input  logic                    nRESET,

	// Palette write from the CPU side
	input  logic                    palWrite,
	input  neoVideoPkg::palAddrT    palAddr,
	input  neoVideoPkg::colorWordT  palData,

	// Pixel stream from the renderer
	input  neoVideoPkg::pixelIndexT pixelIndex,
	input  logic                    palBank,
	input  logic                    shadow,
	input  logic                    videoEnable,
	input  logic                    hBlankIn,
	input  logic                    vBlankIn,

	// Video out
	output neoVideoPkg::channelT    red,
	output neoVideoPkg::channelT    green,
	output neoVideoPkg::channelT    blue,
	output logic                    hBlank,
	output logic                    vBlank,
	output logic                    cePixel
);

	logic pixelCe;

	pixelBus pixBus ();

	// 6 MHz pixel enable
	pixelClockGen clockGen (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixelCe (pixelCe)
	);

	// Palette RAM and read stage
	paletteLookup lookup (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.pixelCe     (pixelCe),
		.palWrite    (palWrite),
		.palAddr     (palAddr),
		.palData     (palData),
		.pixelIndex  (pixelIndex),
		.palBank     (palBank),
		.shadow      (shadow),
		.videoEnable (videoEnable),
		.hBlank      (hBlankIn),
		.vBlank      (vBlankIn),
		.pixOut      (pixBus.source)
	);

	// RGB expansion and output registers
	colorConvert convert (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixIn   (pixBus.sink),
		.red     (red),
		.green   (green),
		.blue    (blue),
		.hBlank  (hBlank),
		.vBlank  (vBlank),
		.cePixel (cePixel)
	);

endmodule

//--- tests/tbNeoVideo.sv
// Testbench for the video output path
// Palette model, reference colour expansion and pixel scoreboard
// Clock, reset, palette writes, pixel stimulus and timeout

`timescale 1ns/100ps

module tbNeoVideo;

	localparam int TIMEOUT_CYCLES = 5000;
	localparam int RANDOM_WRITES  = 48;

	// One sampled pixel as the scoreboard expects it
	typedef struct packed {
		neoVideoPkg::colorWordT word;
		logic                   shadow;
		logic                   enable;
		logic                   hBlank;
		logic                   vBlank;
	} pixelEntryT;

	logic                    CLK_48M;
	logic                    nRESET;
	logic                    palWrite;
	neoVideoPkg::palAddrT    palAddr;
	neoVideoPkg::colorWordT  palData;
	neoVideoPkg::pixelIndexT pixelIndex;
	logic                    palBank;
	logic                    shadow;
	logic                    videoEnable;
	logic                    hBlankIn;
	logic                    vBlankIn;
	neoVideoPkg::channelT    red;
	neoVideoPkg::channelT    green;
	neoVideoPkg::channelT    blue;
	logic                    hBlank;
	logic                    vBlank;
	logic                    cePixel;

	integer seed = 91;
	int cycleCount = 0;
	int comparedCount = 0;

	// Mirror of the pixel divider counted from reset
	logic [2:0] phase;
	logic       ceDelay1;
	logic       ceDelay2;

	neoVideoPkg::colorWordT modelPal [neoVideoPkg::PAL_DEPTH];
	neoVideoPkg::palAddrT   randAddr [RANDOM_WRITES];
	pixelEntryT             pending [$];

	neoVideoOut u_dut (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.palWrite    (palWrite),
		.palAddr     (palAddr),
		.palData     (palData),
		.pixelIndex  (pixelIndex),
		.palBank     (palBank),
		.shadow      (shadow),
		.videoEnable (videoEnable),
		.hBlankIn    (hBlankIn),
		.vBlankIn    (vBlankIn),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.hBlank      (hBlank),
		.vBlank      (vBlank),
		.cePixel     (cePixel)
	);

	// 125 MHz stand-in for the 48 MHz clock
	initial begin
		CLK_48M = 1'b0;
		forever begin
			#4 CLK_48M = ~CLK_48M;
		end
	end

	// ==============================
	// Reference model
	// ==============================

	// Six-bit level less the dark bit and clamped, then widened by its bits 4 and 3
	function automatic neoVideoPkg::channelT expandLevel(
		input logic [3:0] nibble,
		input logic       lowBit,
		input logic       dark
	);
		int level;
		level = int'(nibble) * 4 + int'(lowBit) * 2 + int'(nibble[3]);
		level = level - int'(dark);
		if (level < 0) begin
			level = 0;
		end
		return neoVideoPkg::channelT'(level * 4 + (level / 8) % 4);
	endfunction

	function automatic logic [23:0] expectRgb(
		input neoVideoPkg::colorWordT word,
		input logic                   shade,
		input logic                   enable
	);
		neoVideoPkg::channelT r;
		neoVideoPkg::channelT g;
		neoVideoPkg::channelT b;
		if (!enable) begin
			return 24'd0;
		end
		r = expandLevel(word[11:8], word[14], word[15]);
		g = expandLevel(word[7:4], word[13], word[15]);
		b = expandLevel(word[3:0], word[12], word[15]);
		if (shade) begin
			r = r / 2;
			g = g / 2;
			b = b / 2;
		end
		return {r, g, b};
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Samples the pixel inputs where the DUT does, and tracks palette writes
	always @(posedge CLK_48M) begin : palModel
		pixelEntryT entry;
		if (!nRESET) begin
			phase    <= 3'd0;
			ceDelay1 <= 1'b0;
			ceDelay2 <= 1'b0;
		end else begin
			if (phase == 3'd7) begin
				entry = {modelPal[{palBank, pixelIndex}], shadow, videoEnable,
					hBlankIn, vBlankIn};
				pending.push_back(entry);
				phase <= 3'd0;
			end else begin
				phase <= phase + 3'd1;
			end
			ceDelay1 <= (phase == 3'd7);
			ceDelay2 <= ceDelay1;
		end
		// Read above sees the old word
		if (palWrite) begin
			modelPal[palAddr] = palData;
		end
	end

	// Compares each output pixel with the oldest sampled one
	always @(posedge CLK_48M) begin : scoreboard
		pixelEntryT  entry;
		logic [23:0] expected;
		if (nRESET) begin
			checkValue("cePixel", 32'(cePixel), 32'(ceDelay2));
			if (cePixel) begin
				if (pending.size() == 0) begin
					$display("Output pixel at %0t with no sampled pixel pending", $time);
					$display("=== FAIL ===");
					$fatal(1, "Scoreboard empty");
				end else begin
					entry    = pending.pop_front();
					expected = expectRgb(entry.word, entry.shadow, entry.enable);
					checkValue("red", 32'(red), 32'(expected[23:16]));
					checkValue("green", 32'(green), 32'(expected[15:8]));
					checkValue("blue", 32'(blue), 32'(expected[7:0]));
					checkValue("hBlank", 32'(hBlank), 32'(entry.hBlank));
					checkValue("vBlank", 32'(vBlank), 32'(entry.vBlank));
					comparedCount++;
				end
			end
		end
	end

	always @(posedge CLK_48M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic writePal(input neoVideoPkg::palAddrT addr,
		input neoVideoPkg::colorWordT data);
		@(posedge CLK_48M);
		palWrite <= 1'b1;
		palAddr  <= addr;
		palData  <= data;
	endtask

	task automatic endWrites();
		@(posedge CLK_48M);
		palWrite <= 1'b0;
	endtask

	// New levels are driven at a sampling edge and taken at the next one
	task automatic sendPixel(input neoVideoPkg::pixelIndexT index, input logic bank,
		input logic shade, input logic enable, input logic hb, input logic vb);
		@(posedge CLK_48M);
		while (phase != 3'd7) begin
			@(posedge CLK_48M);
		end
		pixelIndex  <= index;
		palBank     <= bank;
		shadow      <= shade;
		videoEnable <= enable;
		hBlankIn    <= hb;
		vBlankIn    <= vb;
	endtask

	// Returns once the last driven pixel is on the outputs
	task automatic awaitPixelOut();
		@(posedge CLK_48M);
		while (phase != 3'd7) begin
			@(posedge CLK_48M);
		end
		@(negedge CLK_48M);
		while (!cePixel) begin
			@(negedge CLK_48M);
		end
	endtask

	task automatic writeRandomPalette();
		logic [31:0] r;
		for (int i = 0; i < RANDOM_WRITES; i++) begin
			r = $random(seed);
			randAddr[i] = r[12:0];
			r = $random(seed);
			writePal(randAddr[i], r[15:0]);
		end
	endtask

	// Each written entry plain, shadowed and with video off
	task automatic readRandomPalette();
		logic [31:0] r;
		for (int i = 0; i < RANDOM_WRITES; i++) begin
			r = $random(seed);
			sendPixel(randAddr[i][11:0], randAddr[i][12], 1'b0, 1'b1, r[0], r[1]);
			sendPixel(randAddr[i][11:0], randAddr[i][12], 1'b1, 1'b1, r[2], r[3]);
			sendPixel(randAddr[i][11:0], randAddr[i][12], r[4], 1'b0, r[5], r[6]);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		nRESET      = 1'b0;
		palWrite    = 1'b0;
		palAddr     = '0;
		palData     = '0;
		pixelIndex  = '0;
		palBank     = 1'b0;
		shadow      = 1'b0;
		videoEnable = 1'b0;
		hBlankIn    = 1'b0;
		vBlankIn    = 1'b0;

		repeat (8) @(posedge CLK_48M);
		nRESET <= 1'b1;
		@(negedge CLK_48M);
		checkValue("red after reset", 32'(red), 32'd0);
		checkValue("green after reset", 32'(green), 32'd0);
		checkValue("blue after reset", 32'(blue), 32'd0);
		checkValue("hBlank after reset", 32'(hBlank), 32'd0);
		checkValue("vBlank after reset", 32'(vBlank), 32'd0);
		checkValue("cePixel after reset", 32'(cePixel), 32'd0);

		writeRandomPalette();
		writePal(13'h0010, 16'h8000);
		writePal(13'h0011, 16'hFFFF);
		writePal(13'h0012, 16'h7FFF);
		writePal(13'h0013, 16'h8421);
		// One word per bank at the same index
		writePal(13'h0020, 16'h1234);
		writePal(13'h1020, 16'hABCD);
		endWrites();

		// Dark bit on zero and on full channels at the outputs
		sendPixel(12'h010, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		awaitPixelOut();
		checkValue("dark zero RGB", 32'({red, green, blue}), 32'h000000);
		sendPixel(12'h011, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		awaitPixelOut();
		checkValue("dark full RGB", 32'({red, green, blue}), 32'hFBFBFB);

		readRandomPalette();

		for (int i = 0; i < 4; i++) begin
			sendPixel(12'h010 + 12'(i), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
			sendPixel(12'h010 + 12'(i), 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
		end
		sendPixel(12'h011, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
		sendPixel(12'h020, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
		sendPixel(12'h020, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
		sendPixel(12'h020, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);

		// Idle pixel after the last one before draining
		sendPixel(12'h000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		repeat (4) @(posedge CLK_48M);
		@(negedge CLK_48M);

		if (pending.size() == 0 && comparedCount > 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("Pixels left unchecked, %0d pending and %0d compared",
				pending.size(), comparedCount);
			$display("=== FAIL ===");
			$fatal(1, "Scoreboard not drained");
		end
	end

endmodule

//--- neoVideoOut.f
verilog/neoVideoPkg.sv
verilog/pixelBus.sv
verilog/pixelClockGen.sv
verilog/paletteLookup.sv
verilog/colorConvert.sv
verilog/neoVideoOut.sv
tests/tbNeoVideo.sv

//--- run.sh
#!/bin/sh
# Builds the video output testbench with Verilator and runs it.
# The exit status is nonzero if the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbNeoVideo \
	-f neoVideoOut.f \
	--Mdir obj_dir \
	-o tbNeoVideo
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tbNeoVideo
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0
